// ==== all.f ====
+incdir+test
hdl/commit_pkg.sv
hdl/commit_ring.sv
hdl/commit_entry.sv
hdl/issue_select.sv
hdl/writeback_arbiter.sv
hdl/commit_window.sv
test/tb_commit_window.sv

// ==== hdl/commit_entry.sv ====
////////////////////////////////////////////////////////////
// commit window entry
// holds one instruction, wakes its operands as producers
// finish, and tracks execution and writeback
////////////////////////////////////////////////////////////

`timescale 1ns/1ps

module commit_entry (
	input  logic clk,
	input  logic reset,
	input  logic load,
	input  commit_pkg::dispatch_t instr,
	input  logic kill,
	input  logic retire,
	input  logic [commit_pkg::COMMIT_DEPTH-1:0] done_vec,
	input  logic issue_grant,
	input  logic wb_ack,
	output commit_pkg::entry_status_t status,
	output logic [commit_pkg::ARCH_REG_W-1:0] rd,
	output commit_pkg::unit_e unit
);
	localparam int CNT_W = $clog2(commit_pkg::MUL_LATENCY + 1);

	commit_pkg::dispatch_t r_instr;

	logic valid;
	logic issued;
	logic busy;
	logic commit_req;
	logic done;
	logic [CNT_W-1:0] cnt;
	logic [CNT_W-1:0] latency;
	logic finish;
	logic [1:0] src_ready;

	// swap an in-flight tag for the architectural register once the
	// producing entry reports done
	function automatic commit_pkg::src_t wake(
		input commit_pkg::src_t s,
		input logic [commit_pkg::COMMIT_DEPTH-1:0] dv
	);
		commit_pkg::src_t w;

		w = s;
		if (s.tag.in_flight.in_flight && dv[s.tag.in_flight.idx]) begin
			w.tag.arch.in_flight = 1'b0;
			w.tag.arch.areg = s.arch_reg;
		end
		return w;
	endfunction

	assign latency = (r_instr.unit == commit_pkg::UNIT_MUL) ?
		CNT_W'(commit_pkg::MUL_LATENCY) : CNT_W'(1);

	// single cycle ops finish on the issue edge itself
	assign finish = (issue_grant && (latency == CNT_W'(1))) || (busy && (cnt == CNT_W'(1)));

	always_comb begin
		for (int k = 0; k < 2; k++) begin
			src_ready[k] = !r_instr.src[k].needed || !r_instr.src[k].tag.in_flight.in_flight;
		end
	end

	// a rollback in flight hides the entry from issue and writeback
	assign status.valid = valid;
	assign status.ready_to_issue = valid && !issued && (&src_ready) && !kill;
	assign status.commit_req = commit_req && !kill;
	assign status.done = done;

	assign rd = r_instr.rd;
	assign unit = r_instr.unit;

	// instruction payload, sources rewritten every cycle
	always_ff @(posedge clk) begin
		if (load) begin
			r_instr <= instr;
			for (int k = 0; k < 2; k++) begin
				r_instr.src[k] <= wake(instr.src[k], done_vec);
			end
		end else begin
			for (int k = 0; k < 2; k++) begin
				r_instr.src[k] <= wake(r_instr.src[k], done_vec);
			end
		end
	end

	always_ff @(posedge clk) begin
		if (reset || kill || retire) begin
			valid <= 1'b0;
			issued <= 1'b0;
			busy <= 1'b0;
			commit_req <= 1'b0;
			done <= 1'b0;
			cnt <= '0;
		end else if (load) begin
			valid <= 1'b1;
			issued <= 1'b0;
			busy <= 1'b0;
			commit_req <= 1'b0;
			done <= 1'b0;
			cnt <= '0;
		end else begin
			if (issue_grant) begin
				issued <= 1'b1;
				cnt <= latency - 1'b1;
			end else if (busy) begin
				cnt <= cnt - 1'b1;
			end
			busy <= (issue_grant || busy) && !finish;
			if (finish) begin
				// results wait for a writeback port, others are done now
				if (r_instr.makes_rd) begin
					commit_req <= 1'b1;
				end else begin
					done <= 1'b1;
				end
			end
			if (wb_ack) begin
				commit_req <= 1'b0;
				done <= 1'b1;
			end
		end
	end

endmodule

// ==== hdl/commit_pkg.sv ====
////////////////////////////////////////////////////////////
// commit window definitions
// sizes, unit classes, the source tag encoding and the
// structs passed between window entries and shared logic
////////////////////////////////////////////////////////////

package commit_pkg;

	// window geometry
	localparam int COMMIT_DEPTH = 16;
	localparam int COMMIT_IDX_W = 4;
	localparam int ARCH_REG_W = 5;

	// most entries retired in one cycle
	localparam int RETIRE_MAX = 4;

	// cycles from issue to finish for the multiply class
	localparam int MUL_LATENCY = 3;

	// ALU finishes one cycle after issue, MUL after MUL_LATENCY
	typedef enum logic {
		UNIT_ALU = 1'b0,
		UNIT_MUL = 1'b1
	} unit_e;

	// tag seen as a pointer to the producing window entry
	typedef struct packed {
		logic in_flight;
		logic pad;
		logic [COMMIT_IDX_W-1:0] idx;
	} src_in_flight_t;

	// tag seen as an architectural register once the producer is done
	typedef struct packed {
		logic in_flight;
		logic [ARCH_REG_W-1:0] areg;
	} src_arch_t;

	// the top bit says which view applies
	typedef union packed {
		src_in_flight_t in_flight;
		src_arch_t arch;
	} src_tag_u;

	typedef struct packed {
		src_tag_u tag;
		logic [ARCH_REG_W-1:0] arch_reg;
		logic needed;
	} src_t;

	typedef struct packed {
		src_t [1:0] src;
		logic [ARCH_REG_W-1:0] rd;
		logic makes_rd;
		unit_e unit;
	} dispatch_t;

	typedef struct packed {
		logic valid;
		logic ready_to_issue;
		logic commit_req;
		logic done;
	} entry_status_t;

	typedef struct packed {
		logic valid;
		logic [COMMIT_IDX_W-1:0] idx;
		logic [ARCH_REG_W-1:0] rd;
	} wb_grant_t;

endpackage

// ==== hdl/commit_ring.sv ====
////////////////////////////////////////////////////////////
// commit ring control
// head and tail pointers, free entry count, alloc decode,
// rollback kill range and in-order retirement
////////////////////////////////////////////////////////////

`timescale 1ns/1ps

module commit_ring (
	input  logic clk,
	input  logic reset,
	input  logic alloc,
	input  logic rollback,
	input  logic [commit_pkg::COMMIT_IDX_W-1:0] rollback_idx,
	input  commit_pkg::entry_status_t [commit_pkg::COMMIT_DEPTH-1:0] status,
	output logic [commit_pkg::COMMIT_IDX_W-1:0] head,
	output logic [commit_pkg::COMMIT_IDX_W-1:0] tail,
	output logic [commit_pkg::COMMIT_IDX_W:0] available,
	output logic [commit_pkg::COMMIT_DEPTH-1:0] load,
	output logic [commit_pkg::COMMIT_DEPTH-1:0] kill,
	output logic [commit_pkg::COMMIT_DEPTH-1:0] retire,
	output logic [commit_pkg::COMMIT_IDX_W:0] retire_count
);
	localparam int IDX_W = commit_pkg::COMMIT_IDX_W;
	localparam int DEPTH = commit_pkg::COMMIT_DEPTH;
	localparam logic [IDX_W:0] ALL_FREE = (IDX_W + 1)'(DEPTH);

	logic alloc_ok;
	logic [IDX_W-1:0] rb_off;
	logic [IDX_W:0] survivors;

	// rollback wins, and a full window drops the alloc
	assign alloc_ok = alloc && !rollback && (available != '0);

	// age of the surviving branch relative to head
	assign rb_off = rollback_idx - head;
	// 1 to DEPTH entries remain, the branch included
	assign survivors = {1'b0, rb_off} + 1'b1;

	always_comb begin
		logic [IDX_W-1:0] off;

		for (int i = 0; i < DEPTH; i++) begin
			off = IDX_W'(i) - head;
			load[i] = alloc_ok && (IDX_W'(i) == tail);
			// only entries younger than the branch are killed
			kill[i] = rollback && status[i].valid && (off > rb_off);
		end
	end

	// consecutive done entries from head, stopping at the first gap
	always_comb begin
		logic [IDX_W-1:0] idx;
		logic run;

		retire = '0;
		retire_count = '0;
		run = 1'b1;
		for (int k = 0; k < commit_pkg::RETIRE_MAX; k++) begin
			idx = head + IDX_W'(k);
			if (run && status[idx].valid && status[idx].done && !kill[idx]) begin
				retire[idx] = 1'b1;
				retire_count = retire_count + 1'b1;
			end else begin
				run = 1'b0;
			end
		end
	end

	always_ff @(posedge clk) begin
		if (reset) begin
			head <= '0;
			tail <= '0;
			available <= ALL_FREE;
		end else begin
			head <= head + retire_count[IDX_W-1:0];
			if (rollback) begin
				tail <= rollback_idx + 1'b1;
				available <= ALL_FREE - (survivors - retire_count);
			end else begin
				if (alloc_ok) begin
					tail <= tail + 1'b1;
				end
				available <= available + retire_count - {{IDX_W{1'b0}}, alloc_ok};
			end
		end
	end

endmodule

// ==== hdl/commit_window.sv ====
////////////////////////////////////////////////////////////
// commit window top level
// circular reorder window with wake-up, oldest-first issue,
// writeback arbitration, in-order retire and rollback
////////////////////////////////////////////////////////////

`timescale 1ns/1ps

module commit_window #(
	parameter int WB_PORTS = 2
) (
	input  logic clk,
	input  logic reset,
	input  logic alloc,
	input  commit_pkg::dispatch_t alloc_instr,
	input  logic rollback,
	input  logic [commit_pkg::COMMIT_IDX_W-1:0] rollback_idx,
	output logic [commit_pkg::COMMIT_IDX_W-1:0] alloc_idx,
	output logic [commit_pkg::COMMIT_IDX_W:0] available,
	output logic issue_valid,
	output logic [commit_pkg::COMMIT_IDX_W-1:0] issue_idx,
	output commit_pkg::unit_e issue_unit,
	output commit_pkg::wb_grant_t [WB_PORTS-1:0] wb_grant,
	output logic [commit_pkg::COMMIT_IDX_W:0] retire_count,
	output logic [commit_pkg::COMMIT_IDX_W-1:0] retire_head
);
	localparam int DEPTH = commit_pkg::COMMIT_DEPTH;

	commit_pkg::entry_status_t [DEPTH-1:0] status;
	commit_pkg::unit_e [DEPTH-1:0] units;
	logic [DEPTH-1:0][commit_pkg::ARCH_REG_W-1:0] rds;
	logic [DEPTH-1:0] load;
	logic [DEPTH-1:0] kill;
	logic [DEPTH-1:0] retire;
	logic [DEPTH-1:0] issue_grant;
	logic [DEPTH-1:0] wb_ack;
	logic [DEPTH-1:0] done_vec;
	logic [commit_pkg::COMMIT_IDX_W-1:0] head;

	assign retire_head = head;

	commit_ring commit_ring_inst (
		.clk(clk),
		.reset(reset),
		.alloc(alloc),
		.rollback(rollback),
		.rollback_idx(rollback_idx),
		.status(status),
		.head(head),
		.tail(alloc_idx),
		.available(available),
		.load(load),
		.kill(kill),
		.retire(retire),
		.retire_count(retire_count)
	);

	for (genvar i = 0; i < DEPTH; i++) begin : gen_entry
		// done bits fan back to every entry for operand wake-up
		assign done_vec[i] = status[i].done;

		commit_entry commit_entry_inst (
			.clk(clk),
			.reset(reset),
			.load(load[i]),
			.instr(alloc_instr),
			.kill(kill[i]),
			.retire(retire[i]),
			.done_vec(done_vec),
			.issue_grant(issue_grant[i]),
			.wb_ack(wb_ack[i]),
			.status(status[i]),
			.rd(rds[i]),
			.unit(units[i])
		);
	end

	issue_select issue_select_inst (
		.status(status),
		.head(head),
		.units(units),
		.issue_grant(issue_grant),
		.issue_valid(issue_valid),
		.issue_idx(issue_idx),
		.issue_unit(issue_unit)
	);

	writeback_arbiter #(
		.WB_PORTS(WB_PORTS)
	) writeback_arbiter_inst (
		.status(status),
		.head(head),
		.rds(rds),
		.wb_ack(wb_ack),
		.wb_grant(wb_grant)
	);

endmodule

// ==== hdl/issue_select.sv ====
////////////////////////////////////////////////////////////
// issue selector
// grants the oldest ready entry, counted from head
////////////////////////////////////////////////////////////

`timescale 1ns/1ps

module issue_select (
	input  commit_pkg::entry_status_t [commit_pkg::COMMIT_DEPTH-1:0] status,
	input  logic [commit_pkg::COMMIT_IDX_W-1:0] head,
	input  commit_pkg::unit_e [commit_pkg::COMMIT_DEPTH-1:0] units,
	output logic [commit_pkg::COMMIT_DEPTH-1:0] issue_grant,
	output logic issue_valid,
	output logic [commit_pkg::COMMIT_IDX_W-1:0] issue_idx,
	output commit_pkg::unit_e issue_unit
);
	localparam int IDX_W = commit_pkg::COMMIT_IDX_W;
	localparam int DEPTH = commit_pkg::COMMIT_DEPTH;

	logic [DEPTH-1:0] ready;
	logic [2*DEPTH-1:0] doubled;
	logic [DEPTH-1:0] rotated;

	always_comb begin
		for (int i = 0; i < DEPTH; i++) begin
			ready[i] = status[i].ready_to_issue;
		end
	end

	// bit 0 of rotated is the entry at head
	assign doubled = {ready, ready} >> head;
	assign rotated = doubled[DEPTH-1:0];

	always_comb begin
		logic [IDX_W-1:0] first;

		first = '0;
		// scan down so the lowest set offset is left standing
		for (int k = DEPTH - 1; k >= 0; k--) begin
			if (rotated[k]) begin
				first = IDX_W'(k);
			end
		end
		issue_valid = |rotated;
		issue_idx = head + first;
		issue_unit = units[issue_idx];
		issue_grant = '0;
		issue_grant[issue_idx] = issue_valid;
	end

endmodule

// ==== hdl/writeback_arbiter.sv ====
////////////////////////////////////////////////////////////
// writeback arbiter
// hands up to WB_PORTS writeback ports to requesting
// entries in age order, port 0 to the oldest
////////////////////////////////////////////////////////////

`timescale 1ns/1ps

module writeback_arbiter #(
	parameter int WB_PORTS = 2
) (
	input  commit_pkg::entry_status_t [commit_pkg::COMMIT_DEPTH-1:0] status,
	input  logic [commit_pkg::COMMIT_IDX_W-1:0] head,
	input  logic [commit_pkg::COMMIT_DEPTH-1:0][commit_pkg::ARCH_REG_W-1:0] rds,
	output logic [commit_pkg::COMMIT_DEPTH-1:0] wb_ack,
	output commit_pkg::wb_grant_t [WB_PORTS-1:0] wb_grant
);
	localparam int IDX_W = commit_pkg::COMMIT_IDX_W;
	localparam int DEPTH = commit_pkg::COMMIT_DEPTH;
	localparam int PORT_W = $clog2(WB_PORTS + 1);

	always_comb begin
		logic [IDX_W-1:0] idx;
		logic [PORT_W-1:0] n;

		wb_ack = '0;
		wb_grant = '0;
		n = '0;
		// walk from head so older requests take the lower ports
		for (int k = 0; k < DEPTH; k++) begin
			idx = head + IDX_W'(k);
			if (status[idx].commit_req && (n < WB_PORTS)) begin
				wb_grant[n].valid = 1'b1;
				wb_grant[n].idx = idx;
				wb_grant[n].rd = rds[idx];
				wb_ack[idx] = 1'b1;
				n = n + 1'b1;
			end
		end
		// younger requesters past the last port keep commit_req and retry
	end

endmodule

// ==== test/commit_model.svh ====
////////////////////////////////////////////////////////////
// commit window reference model
// eval_window gives the outputs expected in a cycle and
// step_window applies the clock edge that ends it
////////////////////////////////////////////////////////////

localparam int DEPTH = commit_pkg::COMMIT_DEPTH;

logic [DEPTH-1:0] ent_valid;
logic [DEPTH-1:0] ent_issued;
logic [DEPTH-1:0] ent_busy;
logic [DEPTH-1:0] ent_req;
logic [DEPTH-1:0] ent_done;
logic [DEPTH-1:0] ent_mul;
logic [DEPTH-1:0] ent_makes_rd;
logic [DEPTH-1:0][commit_pkg::ARCH_REG_W-1:0] ent_rd;
// a source waits while it is needed and its producer is not done
logic [DEPTH-1:0][1:0] src_wait;
logic [DEPTH-1:0][1:0][commit_pkg::COMMIT_IDX_W-1:0] src_idx;
int ent_rem [DEPTH];
int ring_head;
int ring_tail;
int ring_avail;

// expected results of the current cycle
logic [DEPTH-1:0] kill_vec;
logic [DEPTH-1:0] retire_vec;
logic [DEPTH-1:0] issue_vec;
logic [DEPTH-1:0] ack_vec;
logic exp_issue_valid;
int exp_issue_idx;
int exp_retire_count;
commit_pkg::wb_grant_t [WB_PORTS-1:0] exp_wb;

function automatic int age(input int i);
	return (i - ring_head + DEPTH) % DEPTH;
endfunction

task automatic reset_model();
	ent_valid = '0;
	ent_issued = '0;
	ent_busy = '0;
	ent_req = '0;
	ent_done = '0;
	src_wait = '0;
	ring_head = 0;
	ring_tail = 0;
	ring_avail = DEPTH;
endtask

task automatic eval_window(input logic rb, input int rb_idx);
	int idx;
	int n;
	logic run;

	for (int i = 0; i < DEPTH; i++) begin
		// strictly younger than the surviving branch
		kill_vec[i] = rb && ent_valid[i] && (age(i) > age(rb_idx));
	end
	exp_issue_valid = 1'b0;
	exp_issue_idx = 0;
	issue_vec = '0;
	ack_vec = '0;
	exp_wb = '0;
	n = 0;
	// both issue and writeback walk the window oldest first
	for (int k = 0; k < DEPTH; k++) begin
		idx = (ring_head + k) % DEPTH;
		if (!exp_issue_valid && ent_valid[idx] && !ent_issued[idx] &&
				src_wait[idx] == 2'b00 && !kill_vec[idx]) begin
			exp_issue_valid = 1'b1;
			exp_issue_idx = idx;
			issue_vec[idx] = 1'b1;
		end
		if (ent_req[idx] && !kill_vec[idx] && n < WB_PORTS) begin
			exp_wb[n].valid = 1'b1;
			exp_wb[n].idx = commit_pkg::COMMIT_IDX_W'(idx);
			exp_wb[n].rd = ent_rd[idx];
			ack_vec[idx] = 1'b1;
			n++;
		end
	end
	retire_vec = '0;
	exp_retire_count = 0;
	run = 1'b1;
	for (int k = 0; k < commit_pkg::RETIRE_MAX; k++) begin
		idx = (ring_head + k) % DEPTH;
		run = run && ent_valid[idx] && ent_done[idx] && !kill_vec[idx];
		if (run) begin
			retire_vec[idx] = 1'b1;
			exp_retire_count++;
		end
	end
endtask

task automatic step_window(input logic alloc_in, input commit_pkg::dispatch_t ins,
	input logic rb, input int rb_idx);
	logic [DEPTH-1:0] done_now;
	logic alloc_ok;

	done_now = ent_done;
	alloc_ok = alloc_in && !rb && ring_avail != 0;
	for (int i = 0; i < DEPTH; i++) begin
		for (int s = 0; s < 2; s++) begin
			if (done_now[src_idx[i][s]]) begin
				src_wait[i][s] = 1'b0;
			end
		end
		if (kill_vec[i] || retire_vec[i]) begin
			ent_valid[i] = 1'b0;
			ent_issued[i] = 1'b0;
			ent_busy[i] = 1'b0;
			ent_req[i] = 1'b0;
			ent_done[i] = 1'b0;
		end else if (alloc_ok && i == ring_tail) begin
			ent_valid[i] = 1'b1;
			ent_issued[i] = 1'b0;
			ent_busy[i] = 1'b0;
			ent_req[i] = 1'b0;
			ent_done[i] = 1'b0;
			ent_mul[i] = (ins.unit == commit_pkg::UNIT_MUL);
			ent_makes_rd[i] = ins.makes_rd;
			ent_rd[i] = ins.rd;
			for (int s = 0; s < 2; s++) begin
				src_idx[i][s] = ins.src[s].tag.in_flight.idx;
				src_wait[i][s] = ins.src[s].needed && ins.src[s].tag.in_flight.in_flight &&
					!done_now[ins.src[s].tag.in_flight.idx];
			end
		end else begin
			if (issue_vec[i]) begin
				ent_issued[i] = 1'b1;
				ent_busy[i] = 1'b1;
				ent_rem[i] = ent_mul[i] ? commit_pkg::MUL_LATENCY : 1;
			end
			if (ent_busy[i]) begin
				ent_rem[i]--;
				// on finishing results wait for writeback and others are done
				if (ent_rem[i] == 0) begin
					ent_busy[i] = 1'b0;
					ent_req[i] = ent_makes_rd[i];
					ent_done[i] = !ent_makes_rd[i];
				end
			end
			if (ack_vec[i]) begin
				ent_req[i] = 1'b0;
				ent_done[i] = 1'b1;
			end
		end
	end
	if (rb) begin
		ring_tail = (rb_idx + 1) % DEPTH;
	end else if (alloc_ok) begin
		ring_tail = (ring_tail + 1) % DEPTH;
	end
	ring_head = (ring_head + exp_retire_count) % DEPTH;
	// every entry that holds no instruction is free
	ring_avail = DEPTH;
	for (int i = 0; i < DEPTH; i++) begin
		if (ent_valid[i]) begin
			ring_avail--;
		end
	end
endtask

// ==== test/tb_commit_window.sv ====
////////////////////////////////////////////////////////////
// commit window testbench
// random dispatch, dependencies and rollback, checked
// every cycle against a model of the window
////////////////////////////////////////////////////////////

`timescale 1ns/1ps

module tb_commit_window;
	localparam int WB_PORTS = 2;
	localparam int IDX_W = commit_pkg::COMMIT_IDX_W;
	localparam int RESET_CYCLES = 8;
	localparam int EMPTY_CYCLES = 4;
	localparam int FILL_CYCLES = 300;
	localparam int DEP_CYCLES = 400;
	localparam int ROLL_CYCLES = 400;
	localparam int CYCLE_LIMIT =
		4 * (RESET_CYCLES + EMPTY_CYCLES + FILL_CYCLES + DEP_CYCLES + ROLL_CYCLES);

	logic clk = 1'b0;
	logic reset;
	logic alloc;
	commit_pkg::dispatch_t alloc_instr;
	logic rollback;
	logic [IDX_W-1:0] rollback_idx;
	logic [IDX_W-1:0] alloc_idx;
	logic [IDX_W:0] available;
	logic issue_valid;
	logic [IDX_W-1:0] issue_idx;
	commit_pkg::unit_e issue_unit;
	commit_pkg::wb_grant_t [WB_PORTS-1:0] wb_grant;
	logic [IDX_W:0] retire_count;
	logic [IDX_W-1:0] retire_head;

	integer seed = 91;
	int errors = 0;
	int cycles = 0;
	int mul_issues = 0;
	int alu_issues = 0;

	`include "commit_model.svh"

	commit_window #(
		.WB_PORTS(WB_PORTS)
	) commit_window_inst (
		.clk(clk),
		.reset(reset),
		.alloc(alloc),
		.alloc_instr(alloc_instr),
		.rollback(rollback),
		.rollback_idx(rollback_idx),
		.alloc_idx(alloc_idx),
		.available(available),
		.issue_valid(issue_valid),
		.issue_idx(issue_idx),
		.issue_unit(issue_unit),
		.wb_grant(wb_grant),
		.retire_count(retire_count),
		.retire_head(retire_head)
	);

	always #10 clk = ~clk;

	always @(posedge clk) begin
		cycles <= cycles + 1;
		if (cycles >= CYCLE_LIMIT) begin
			$display("timeout: the run went past %0d cycles", CYCLE_LIMIT);
			$display("ERRORS FOUND");
			$finish;
		end
	end

	task automatic check_count(input string name, input logic [IDX_W:0] got,
		input logic [IDX_W:0] exp);
		if (got !== exp) begin
			$display("[ERROR] %s: got 0x%0h, expected 0x%0h", name, got, exp);
			errors++;
		end
	endtask

	task automatic check_idx(input string name, input logic [IDX_W-1:0] got,
		input logic [IDX_W-1:0] exp);
		if (got !== exp) begin
			$display("[ERROR] %s: got 0x%0h, expected 0x%0h", name, got, exp);
			errors++;
		end
	endtask

	task automatic check_flag(input string name, input logic got, input logic exp);
		if (got !== exp) begin
			$display("[ERROR] %s: got 0x%0h, expected 0x%0h", name, got, exp);
			errors++;
		end
	endtask

	task automatic check_unit(input string name, input commit_pkg::unit_e got,
		input commit_pkg::unit_e exp);
		if (got !== exp) begin
			$display("[ERROR] %s: got 0x%0h, expected 0x%0h", name, got, exp);
			errors++;
		end
	endtask

	task automatic check_grant(input string name, input commit_pkg::wb_grant_t got,
		input commit_pkg::wb_grant_t exp);
		// idx and rd only carry meaning on a valid port
		if (got.valid !== exp.valid || (exp.valid && got !== exp)) begin
			$display("[ERROR] %s: got 0x%0h, expected 0x%0h", name, got, exp);
			errors++;
		end
	endtask

	// sources only point at entries that are in the window and not done
	function automatic commit_pkg::dispatch_t make_instr(input int dep_pct);
		commit_pkg::dispatch_t ins;
		int q[$];

		for (int i = 0; i < DEPTH; i++) begin
			if (ent_valid[i] && !ent_done[i]) begin
				q.push_back(i);
			end
		end
		ins.rd = $random(seed);
		ins.makes_rd = ($random(seed) & 3) != 0;
		ins.unit = ($random(seed) & 1) ? commit_pkg::UNIT_MUL : commit_pkg::UNIT_ALU;
		for (int s = 0; s < 2; s++) begin
			ins.src[s].needed = $random(seed);
			ins.src[s].arch_reg = $random(seed);
			ins.src[s].tag.arch.in_flight = 1'b0;
			ins.src[s].tag.arch.areg = $random(seed);
			if (q.size() > 0 && ($unsigned($random(seed)) % 100) < dep_pct) begin
				ins.src[s].tag.in_flight.in_flight = 1'b1;
				ins.src[s].tag.in_flight.pad = 1'b0;
				ins.src[s].tag.in_flight.idx = q[$unsigned($random(seed)) % q.size()];
			end
		end
		return ins;
	endfunction

	// drive 1 ns after the edge, compare at the falling edge, then step the model
	task automatic run_cycle(input logic a, input logic rb, input int rb_idx,
		input int dep_pct);
		commit_pkg::unit_e exp_unit;

		alloc = a;
		alloc_instr = make_instr(dep_pct);
		rollback = rb;
		rollback_idx = rb_idx;
		@(negedge clk);
		eval_window(rb, rb_idx);
		check_idx("alloc_idx", alloc_idx, ring_tail);
		check_count("available", available, ring_avail);
		check_flag("issue_valid", issue_valid, exp_issue_valid);
		if (exp_issue_valid) begin
			exp_unit = ent_mul[exp_issue_idx] ? commit_pkg::UNIT_MUL : commit_pkg::UNIT_ALU;
			check_idx("issue_idx", issue_idx, exp_issue_idx);
			check_unit("issue_unit", issue_unit, exp_unit);
			if (ent_mul[exp_issue_idx]) begin
				mul_issues++;
			end else begin
				alu_issues++;
			end
		end
		for (int p = 0; p < WB_PORTS; p++) begin
			check_grant($sformatf("wb_grant[%0d]", p), wb_grant[p], exp_wb[p]);
		end
		check_count("retire_count", retire_count, exp_retire_count);
		check_idx("retire_head", retire_head, ring_head);
		step_window(a, alloc_instr, rb, rb_idx);
		@(posedge clk);
		#1;
	endtask

	task automatic run_random(input string name, input int n, input int alloc_pct,
		input int dep_pct, input int rb_pct);
		int start_errors;
		int rb_idx;
		logic rb;
		int q[$];

		start_errors = errors;
		for (int c = 0; c < n; c++) begin
			q = {};
			for (int i = 0; i < DEPTH; i++) begin
				if (ent_valid[i]) begin
					q.push_back(i);
				end
			end
			// the surviving branch is always an entry in the window
			rb = (q.size() > 0) && (($unsigned($random(seed)) % 100) < rb_pct);
			rb_idx = rb ? q[$unsigned($random(seed)) % q.size()] : 0;
			run_cycle(($unsigned($random(seed)) % 100) < alloc_pct, rb, rb_idx, dep_pct);
		end
		$display("test %s: %0d cycles, %0d errors", name, n, errors - start_errors);
	endtask

	initial begin
		reset = 1'b1;
		alloc = 1'b0;
		alloc_instr = '0;
		rollback = 1'b0;
		rollback_idx = '0;
		reset_model();
		repeat (RESET_CYCLES) @(posedge clk);
		#1;
		reset = 1'b0;
		run_random("reset_empty", EMPTY_CYCLES, 0, 0, 0);
		run_random("alloc_retire", FILL_CYCLES, 60, 0, 0);
		run_random("wakeup_issue", DEP_CYCLES, 80, 60, 0);
		if (mul_issues == 0 || alu_issues == 0) begin
			$display("issue mix: the ALU or the MUL class never issued");
			errors++;
		end
		run_random("rollback", ROLL_CYCLES, 70, 40, 8);
		$display("summary: %0d cycles, %0d ALU and %0d MUL issues, %0d errors",
			cycles, alu_issues, mul_issues, errors);
		if (errors == 0) begin
			$display("NO ERRORS");
		end else begin
			$display("ERRORS FOUND");
		end
		$finish;
	end

endmodule
